// File: logic/aes128_pipe.sv
`timescale 1ns/1ps

module aes128_pipe (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  aes_types_pkg::aes_block_t  plaintext,
    input  aes_types_pkg::aes_block_t  key,
    output logic                       out_valid,
    output aes_types_pkg::aes_block_t  ciphertext
);

    aes_types_pkg::aes_block_t white_state;
    aes_types_pkg::aes_block_t white_key;
    aes_types_pkg::aes_block_t state_chain [0:aes_const_pkg::AES_ROUNDS];
    aes_types_pkg::aes_block_t key_chain [0:aes_const_pkg::AES_ROUNDS-1];
    aes_types_pkg::aes_block_t round_key [0:aes_const_pkg::AES_ROUNDS-1];
    logic [aes_const_pkg::AES_LATENCY-1:0] valid_pipe;

    // initial AddRoundKey, the key rides along
    always_ff @(posedge clk)
    begin
        white_state <= plaintext ^ key;
        white_key   <= key;
    end

    assign state_chain[0] = white_state;
    assign key_chain[0]   = white_key;

    for (genvar i = 0; i < aes_const_pkg::AES_ROUNDS; i++)
    begin : g_round
        if (i < aes_const_pkg::AES_ROUNDS - 1)
        begin : g_key
            aes_key_stage u_key_stage (
                .clk       (clk),
                .key_in    (key_chain[i]),
                .rcon      (aes_const_pkg::AES_RCON[i]),
                .round_key (round_key[i]),
                .next_key  (key_chain[i + 1])
            );
        end
        else
        begin : g_key_last
            aes_key_stage u_key_stage (
                .clk       (clk),
                .key_in    (key_chain[i]),
                .rcon      (aes_const_pkg::AES_RCON[i]),
                .round_key (round_key[i]),
                .next_key  ()  // no round after the last
            );
        end

        aes_round #(
            .last_round (i == aes_const_pkg::AES_ROUNDS - 1)
        ) u_round (
            .clk       (clk),
            .state_in  (state_chain[i]),
            .round_key (round_key[i]),
            .state_out (state_chain[i + 1])
        );
    end

    assign ciphertext = state_chain[aes_const_pkg::AES_ROUNDS];

    // one valid bit per pipeline stage
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_pipe <= '0;
        end
        else
        begin
            valid_pipe <= {valid_pipe[aes_const_pkg::AES_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[aes_const_pkg::AES_LATENCY-1];

endmodule

// File: logic/aes_const_pkg.sv
package aes_const_pkg;

    // AES-128 round count
    localparam int AES_ROUNDS = 10;

    // round constants, one per key schedule step
    localparam aes_types_pkg::aes_byte_t AES_RCON [0:AES_ROUNDS-1] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // x^8 + x^4 + x^3 + x + 1, low byte only
    localparam aes_types_pkg::aes_byte_t AES_POLY = 8'h1b;

    // whitening register plus two cycles per round
    localparam int AES_LATENCY = 1 + 2 * AES_ROUNDS;

endpackage

// File: logic/aes_key_stage.sv
`timescale 1ns/1ps

module aes_key_stage (
    input  logic                       clk,
    input  aes_types_pkg::aes_block_t  key_in,
    input  aes_types_pkg::aes_byte_t   rcon,
    output aes_types_pkg::aes_block_t  round_key,
    output aes_types_pkg::aes_block_t  next_key
);

    aes_types_pkg::aes_word_t w [0:3];
    aes_types_pkg::aes_word_t run [0:3];
    aes_types_pkg::aes_word_t run_q [0:3];
    aes_types_pkg::aes_word_t rot_word;
    aes_types_pkg::aes_word_t sub_word;

    assign w[0] = key_in[127:96];
    assign w[1] = key_in[95:64];
    assign w[2] = key_in[63:32];
    assign w[3] = key_in[31:0];

    // running xor of the words with rcon in byte 0 of the first
    always_comb
    begin
        run[0] = w[0] ^ {rcon, 24'h000000};
        run[1] = run[0] ^ w[1];
        run[2] = run[1] ^ w[2];
        run[3] = run[2] ^ w[3];
    end

    always_ff @(posedge clk)
    begin
        run_q <= run;
    end

    assign rot_word = {w[3][23:0], w[3][31:24]};  // RotWord

    // SubWord registered inside the S-boxes in step with run_q
    for (genvar b = 0; b < 4; b++)
    begin : g_sub
        aes_sbox u_sbox (
            .clk  (clk),
            .din  (rot_word[31 - 8 * b -: 8]),
            .dout (sub_word[31 - 8 * b -: 8])
        );
    end

    // valid in the second cycle after key_in
    assign round_key = {run_q[0] ^ sub_word,
                        run_q[1] ^ sub_word,
                        run_q[2] ^ sub_word,
                        run_q[3] ^ sub_word};

    always_ff @(posedge clk)
    begin
        next_key <= round_key;  // lines up with the next round's state_in
    end

endmodule

// File: logic/aes_round.sv
`timescale 1ns/1ps

module aes_round #(
    parameter bit last_round = 1'b0
) (
    input  logic                       clk,
    input  aes_types_pkg::aes_block_t  state_in,
    input  aes_types_pkg::aes_block_t  round_key,
    output aes_types_pkg::aes_block_t  state_out
);

    aes_types_pkg::aes_byte_t sb [0:3][0:3];  // [column][row], registered
    aes_types_pkg::aes_word_t col_mix [0:3];

    for (genvar c = 0; c < 4; c++)
    begin : g_col_sbox
        for (genvar r = 0; r < 4; r++)
        begin : g_row_sbox
            aes_sbox u_sbox (
                .clk  (clk),
                .din  (state_in[127 - 32 * c - 8 * r -: 8]),
                .dout (sb[c][r])
            );
        end
    end

    if (last_round)
    begin : g_final
        // ShiftRows only
        for (genvar j = 0; j < 4; j++)
        begin : g_col
            assign col_mix[j] = {sb[j][0],
                                 sb[(j + 1) % 4][1],
                                 sb[(j + 2) % 4][2],
                                 sb[(j + 3) % 4][3]};
        end
    end
    else
    begin : g_full
        aes_types_pkg::aes_word_t tbox [0:3][0:3];

        for (genvar c = 0; c < 4; c++)
        begin : g_tcol
            for (genvar r = 0; r < 4; r++)
            begin : g_trow
                aes_types_pkg::aes_byte_t dbl;
                aes_types_pkg::aes_word_t base;

                // xtime
                assign dbl = {sb[c][r][6:0], 1'b0}
                           ^ (sb[c][r][7] ? aes_const_pkg::AES_POLY : 8'h00);
                assign base = {dbl, sb[c][r], sb[c][r], dbl ^ sb[c][r]};  // {2s, s, s, 3s}
                // rotate right by one byte per row
                assign tbox[c][r] = aes_types_pkg::aes_word_t'({base, base} >> (8 * r));
            end
        end

        // ShiftRows picks the source column, MixColumns is the xor
        for (genvar j = 0; j < 4; j++)
        begin : g_col
            assign col_mix[j] = tbox[j][0]
                              ^ tbox[(j + 1) % 4][1]
                              ^ tbox[(j + 2) % 4][2]
                              ^ tbox[(j + 3) % 4][3];
        end
    end

    always_ff @(posedge clk)
    begin
        state_out <= {col_mix[0], col_mix[1], col_mix[2], col_mix[3]} ^ round_key;
    end

endmodule

// File: logic/aes_sbox.sv
`timescale 1ns/1ps

module aes_sbox (
    input  logic                      clk,
    input  aes_types_pkg::aes_byte_t  din,
    output aes_types_pkg::aes_byte_t  dout
);

    logic [0:7]  x;  // x[0] is the msb
    logic [0:7]  s;
    logic [21:1] y;
    logic [67:0] t;
    logic [17:0] z;

    assign x = din;

    always_comb
    begin
        // linear top layer
        y[14] = x[3] ^ x[5];
        y[13] = x[0] ^ x[6];
        y[9]  = x[0] ^ x[3];
        y[8]  = x[0] ^ x[5];
        t[0]  = x[1] ^ x[2];
        y[1]  = t[0] ^ x[7];
        y[4]  = y[1] ^ x[3];
        y[12] = y[13] ^ y[14];
        y[2]  = y[1] ^ x[0];
        y[5]  = y[1] ^ x[6];
        y[3]  = y[5] ^ y[8];
        t[1]  = x[4] ^ y[12];
        y[15] = t[1] ^ x[5];
        y[20] = t[1] ^ x[1];
        y[6]  = y[15] ^ x[7];
        y[10] = y[15] ^ t[0];
        y[11] = y[20] ^ y[9];
        y[7]  = x[7] ^ y[11];
        y[17] = y[10] ^ y[11];
        y[19] = y[10] ^ y[8];
        y[16] = t[0] ^ y[11];
        y[21] = y[13] ^ y[16];
        y[18] = x[0] ^ y[16];

        // GF(2^4) inversion core
        t[2]  = y[12] & y[15];
        t[3]  = y[3] & y[6];
        t[4]  = t[3] ^ t[2];
        t[5]  = y[4] & x[7];
        t[6]  = t[5] ^ t[2];
        t[7]  = y[13] & y[16];
        t[8]  = y[5] & y[1];
        t[9]  = t[8] ^ t[7];
        t[10] = y[2] & y[7];
        t[11] = t[10] ^ t[7];
        t[12] = y[9] & y[11];
        t[13] = y[14] & y[17];
        t[14] = t[13] ^ t[12];
        t[15] = y[8] & y[10];
        t[16] = t[15] ^ t[12];
        t[17] = t[4] ^ t[14];
        t[18] = t[6] ^ t[16];
        t[19] = t[9] ^ t[14];
        t[20] = t[11] ^ t[16];
        t[21] = t[17] ^ y[20];
        t[22] = t[18] ^ y[19];
        t[23] = t[19] ^ y[21];
        t[24] = t[20] ^ y[18];
        t[25] = t[21] ^ t[22];
        t[26] = t[21] & t[23];
        t[27] = t[24] ^ t[26];
        t[28] = t[25] & t[27];
        t[29] = t[28] ^ t[22];
        t[30] = t[23] ^ t[24];
        t[31] = t[22] ^ t[26];
        t[32] = t[31] & t[30];
        t[33] = t[32] ^ t[24];
        t[34] = t[23] ^ t[33];
        t[35] = t[27] ^ t[33];
        t[36] = t[24] & t[35];
        t[37] = t[36] ^ t[34];
        t[38] = t[27] ^ t[36];
        t[39] = t[29] & t[38];
        t[40] = t[25] ^ t[39];
        t[41] = t[40] ^ t[37];
        t[42] = t[29] ^ t[33];
        t[43] = t[29] ^ t[40];
        t[44] = t[33] ^ t[37];
        t[45] = t[42] ^ t[41];

        // multiply back into GF(2^8)
        z[0]  = t[44] & y[15];
        z[1]  = t[37] & y[6];
        z[2]  = t[33] & x[7];
        z[3]  = t[43] & y[16];
        z[4]  = t[40] & y[1];
        z[5]  = t[29] & y[7];
        z[6]  = t[42] & y[11];
        z[7]  = t[45] & y[17];
        z[8]  = t[41] & y[10];
        z[9]  = t[44] & y[12];
        z[10] = t[37] & y[3];
        z[11] = t[33] & y[4];
        z[12] = t[43] & y[13];
        z[13] = t[40] & y[5];
        z[14] = t[29] & y[2];
        z[15] = t[42] & y[9];
        z[16] = t[45] & y[14];
        z[17] = t[41] & y[8];

        // linear bottom layer, affine constant folded into the inversions
        t[46] = z[15] ^ z[16];
        t[47] = z[10] ^ z[11];
        t[48] = z[5] ^ z[13];
        t[49] = z[9] ^ z[10];
        t[50] = z[2] ^ z[12];
        t[51] = z[2] ^ z[5];
        t[52] = z[7] ^ z[8];
        t[53] = z[0] ^ z[3];
        t[54] = z[6] ^ z[7];
        t[55] = z[16] ^ z[17];
        t[56] = z[12] ^ t[48];
        t[57] = t[50] ^ t[53];
        t[58] = z[4] ^ t[46];
        t[59] = z[3] ^ t[54];
        t[60] = t[46] ^ t[57];
        t[61] = z[14] ^ t[57];
        t[62] = t[52] ^ t[58];
        t[63] = t[49] ^ t[58];
        t[64] = z[4] ^ t[59];
        t[65] = t[61] ^ t[62];
        t[66] = z[1] ^ t[63];
        t[67] = t[64] ^ t[65];
        s[0]  = t[59] ^ t[63];
        s[3]  = t[53] ^ t[66];
        s[4]  = t[51] ^ t[66];
        s[5]  = t[47] ^ t[65];
        s[6]  = ~t[56] ^ t[62];
        s[7]  = ~t[48] ^ t[60];
        s[1]  = ~t[64] ^ s[3];
        s[2]  = ~t[55] ^ t[67];
    end

    always_ff @(posedge clk)
    begin
        dout <= s;
    end

endmodule

// File: logic/aes_types_pkg.sv
package aes_types_pkg;

    // one state byte, msb first as in FIPS-197
    typedef logic [7:0] aes_byte_t;

    // one state column or key word
    // byte 0 of the column sits in [31:24]
    typedef logic [31:0] aes_word_t;

    // full state or cipher key
    // column 0 sits in [127:96], byte 0 of the block in [127:120]
    typedef logic [127:0] aes_block_t;

endpackage

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module aes_tb -f vlog.f \
    && ./obj_dir/Vaes_tb | tee /dev/stderr | grep -x "Test OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verification/aes_sva.sv
`timescale 1ns/1ps

module aes_sva (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       in_valid,
    input logic                       out_valid,
    input aes_types_pkg::aes_block_t  ciphertext
);

    int cycles;  // since reset, saturates

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cycles <= 0;
        end
        else if (cycles < aes_const_pkg::AES_LATENCY)
        begin
            cycles <= cycles + 1;
        end
    end

    a_fill_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        cycles < aes_const_pkg::AES_LATENCY |-> !out_valid)
        else $error("out_valid high while the pipeline fills after reset");

    a_valid_delay: assert property (@(posedge clk) disable iff (!arst_n)
        cycles == aes_const_pkg::AES_LATENCY
            |-> out_valid == $past(in_valid, aes_const_pkg::AES_LATENCY))
        else $error("out_valid does not follow the delayed in_valid");

    a_known_data: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown(ciphertext))
        else $error("ciphertext unknown while out_valid is high");

endmodule

bind aes128_pipe aes_sva u_sva (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .ciphertext (ciphertext)
);

// File: verification/aes_tb_model.svh
`ifndef AES_TB_MODEL_SVH
`define AES_TB_MODEL_SVH

    // shift and add in GF(2^8)
    function automatic aes_types_pkg::aes_byte_t gf_mul(
        input aes_types_pkg::aes_byte_t a,
        input aes_types_pkg::aes_byte_t b
    );
        aes_types_pkg::aes_byte_t acc;
        aes_types_pkg::aes_byte_t p;
        acc = 8'h00;
        p = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ p;
            p = {p[6:0], 1'b0} ^ (p[7] ? aes_const_pkg::AES_POLY : 8'h00);
        end
        return acc;
    endfunction

    function automatic aes_types_pkg::aes_byte_t sbox_ref(input aes_types_pkg::aes_byte_t b);
        aes_types_pkg::aes_byte_t inv;
        aes_types_pkg::aes_byte_t p;
        p = b;
        inv = 8'h01;
        // b^254 is the field inverse, 0 stays 0
        for (int i = 0; i < 7; i++)
        begin
            p = gf_mul(p, p);
            inv = gf_mul(inv, p);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
             ^ {inv[3:0], inv[7:4]} ^ 8'h63;  // affine map
    endfunction

    // FIPS-197 cipher, state byte 4*c+r is column c row r
    function automatic aes_types_pkg::aes_block_t aes_encrypt(
        input aes_types_pkg::aes_block_t blk,
        input aes_types_pkg::aes_block_t cipher_key
    );
        aes_types_pkg::aes_byte_t st [0:15];
        aes_types_pkg::aes_byte_t sh [0:15];
        aes_types_pkg::aes_word_t w [0:3];
        aes_types_pkg::aes_word_t tmp;
        aes_types_pkg::aes_block_t rk;
        aes_types_pkg::aes_block_t res;
        rk = cipher_key;
        for (int i = 0; i < 16; i++)
            st[i] = blk[127 - 8 * i -: 8] ^ cipher_key[127 - 8 * i -: 8];
        for (int rnd = 0; rnd < aes_const_pkg::AES_ROUNDS; rnd++)
        begin
            for (int j = 0; j < 4; j++)
                w[j] = rk[127 - 32 * j -: 32];
            tmp = {sbox_ref(w[3][23:16]), sbox_ref(w[3][15:8]), sbox_ref(w[3][7:0]),
                   sbox_ref(w[3][31:24])} ^ {aes_const_pkg::AES_RCON[rnd], 24'h000000};
            w[0] = w[0] ^ tmp;
            for (int j = 1; j < 4; j++)
                w[j] = w[j] ^ w[j - 1];
            rk = {w[0], w[1], w[2], w[3]};
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                    sh[4 * c + r] = sbox_ref(st[4 * ((c + r) % 4) + r]);  // sub and shift
            for (int c = 0; c < 4; c++)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    if (rnd < aes_const_pkg::AES_ROUNDS - 1)
                        st[4 * c + r] = gf_mul(sh[4 * c + r], 8'h02)
                                      ^ gf_mul(sh[4 * c + (r + 1) % 4], 8'h03)
                                      ^ sh[4 * c + (r + 2) % 4] ^ sh[4 * c + (r + 3) % 4];
                    else
                        st[4 * c + r] = sh[4 * c + r];
                end
            end
            for (int i = 0; i < 16; i++)
                st[i] = st[i] ^ rk[127 - 8 * i -: 8];
        end
        for (int i = 0; i < 16; i++)
            res[127 - 8 * i -: 8] = st[i];
        return res;
    endfunction

`endif

// File: verification/aes_tb.sv
`timescale 1ns/1ps

module aes_tb;

    logic                       clk;
    logic                       arst_n;
    logic                       in_valid;
    aes_types_pkg::aes_block_t  plaintext;
    aes_types_pkg::aes_block_t  key;
    logic                       out_valid;
    aes_types_pkg::aes_block_t  ciphertext;

    int seed = 32'h223f;
    int edge_cnt = 0;  // rising edges seen so far
    int check_count = 0;
    int error_count = 0;
    int test_count = 0;
    int first_check;
    int first_error;
    bit timed_out = 1'b0;
    bit compare_on = 1'b0;
    aes_types_pkg::aes_block_t exp_ct [$];
    int exp_edge [$];  // edge on which each result is due

    `include "aes_tb_model.svh"

    aes_tb_clk u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    aes128_pipe dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    always @(posedge clk)
    begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_block(input string name, input aes_types_pkg::aes_block_t got,
                               input aes_types_pkg::aes_block_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (compare_on)
        begin
            if (exp_edge.size() > 0 && exp_edge[0] == edge_cnt)
            begin
                check_bit("out_valid", out_valid, 1'b1);
                check_block("ciphertext", ciphertext, exp_ct.pop_front());
                void'(exp_edge.pop_front());
            end
            else
            begin
                check_bit("out_valid", out_valid, 1'b0);
            end
        end
    end

    function automatic aes_types_pkg::aes_block_t rand_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic drive(input logic valid, input aes_types_pkg::aes_block_t pt,
                         input aes_types_pkg::aes_block_t k,
                         input aes_types_pkg::aes_block_t ct);
        @(posedge clk);
        in_valid  <= valid;
        plaintext <= pt;
        key       <= k;
        if (valid)
        begin
            exp_ct.push_back(ct);
            exp_edge.push_back(edge_cnt + 1 + aes_const_pkg::AES_LATENCY);
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        drive(1'b0, plaintext, key, '0);
        while (exp_edge.size() > 0 && waited < aes_const_pkg::AES_LATENCY + 4)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_edge.size() > 0)
        begin
            $display("Timeout: %0d expected results never came out", exp_edge.size());
            timed_out = 1'b1;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic begin_test();
        first_check = check_count;
        first_error = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%s: %0d checks, %0d errors", name, check_count - first_check,
                 error_count - first_error);
    endtask

    task automatic test_reset();
        int waited;
        begin_test();
        waited = 0;
        while (arst_n !== 1'b1 && waited < 10)
        begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1)
        begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end
        compare_on = 1'b1;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        repeat (aes_const_pkg::AES_LATENCY + 4)
            drive(1'b0, '0, '0, '0);
        drain_results();
        end_test("reset");
    endtask

    task automatic test_known_answer();
        aes_types_pkg::aes_block_t pt;
        aes_types_pkg::aes_block_t k;
        aes_types_pkg::aes_block_t ct;
        begin_test();
        pt = 128'h00112233445566778899aabbccddeeff;
        k  = 128'h000102030405060708090a0b0c0d0e0f;
        ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;  // FIPS-197 C.1
        check_block("aes_encrypt", aes_encrypt(pt, k), ct);
        drive(1'b1, pt, k, ct);
        drain_results();
        end_test("known answer");
    endtask

    task automatic test_stream();
        aes_types_pkg::aes_block_t pt;
        aes_types_pkg::aes_block_t k;
        begin_test();
        for (int i = 0; i < 50; i++)
        begin
            pt = rand_block();
            k  = rand_block();
            drive(1'b1, pt, k, aes_encrypt(pt, k));
        end
        drain_results();
        end_test("full throughput");
    endtask

    task automatic test_gaps();
        aes_types_pkg::aes_block_t pt;
        aes_types_pkg::aes_block_t k;
        int gap;
        begin_test();
        for (int i = 0; i < 40; i++)
        begin
            pt  = rand_block();
            k   = rand_block();
            gap = $unsigned($random(seed)) % 4;
            drive(1'b1, pt, k, aes_encrypt(pt, k));
            repeat (gap)
                drive(1'b0, pt, k, '0);
        end
        drain_results();
        end_test("gaps");
    endtask

    task automatic test_idle_data();
        begin_test();
        for (int i = 0; i < 40; i++)
            drive(1'b0, rand_block(), rand_block(), '0);
        repeat (aes_const_pkg::AES_LATENCY + 2)
            drive(1'b0, '0, '0, '0);
        drain_results();
        end_test("ignored data");
    endtask

    initial
    begin
        in_valid  = 1'b0;
        plaintext = '0;
        key       = '0;
        test_reset();
        if (!timed_out)
            test_known_answer();
        if (!timed_out)
            test_stream();
        if (!timed_out)
            test_gaps();
        if (!timed_out)
            test_idle_data();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0 && !timed_out)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verification/aes_tb_clk.sv
`timescale 1ns/1ps

module aes_tb_clk (
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: vlog.f
+incdir+verification
logic/aes_types_pkg.sv
logic/aes_const_pkg.sv
logic/aes_sbox.sv
logic/aes_key_stage.sv
logic/aes_round.sv
logic/aes128_pipe.sv
verification/aes_tb_clk.sv
verification/aes_sva.sv
verification/aes_tb.sv
